// ==== source/scalar_config.svh ====
//////////////////////////////
// Widths, depths and opcode values
// of the scalar unit
//////////////////////////////
`ifndef SCALAR_CONFIG_SVH
`define SCALAR_CONFIG_SVH

// Datapath and register file
`define SCALAR_DATA_WIDTH 32
`define SCALAR_REG_COUNT 16
`define SCALAR_REG_INDEX_WIDTH 4

// Instruction memory
`define SCALAR_IMEM_DEPTH 64
`define SCALAR_ADDR_WIDTH 6

// Instruction fields
`define SCALAR_IMM_WIDTH 12
`define SCALAR_OP_WIDTH 3

// Scalar opcodes
`define SCALAR_OP_NOP 3'd0
`define SCALAR_OP_ADD 3'd1
`define SCALAR_OP_SUB 3'd2
`define SCALAR_OP_AND 3'd3
`define SCALAR_OP_OR 3'd4
`define SCALAR_OP_XOR 3'd5
`define SCALAR_OP_LI 3'd6
`define SCALAR_OP_HALT 3'd7

`endif

// ==== source/scalar_pkg.sv ====
//////////////////////////////
// Types shared by the scalar unit:
// instruction, pipeline and command structs
//////////////////////////////
`default_nettype none

`include "scalar_config.svh"

package scalar_pkg;

	typedef logic [`SCALAR_DATA_WIDTH-1:0] data_t;
	typedef logic [`SCALAR_REG_INDEX_WIDTH-1:0] reg_index_t;
	typedef logic [`SCALAR_OP_WIDTH-1:0] opcode_t;

	// Instruction word, unit bit on top
	typedef struct packed {
		logic unit;
		opcode_t opcode;
		reg_index_t dst;
		reg_index_t src1;
		reg_index_t src2;
		logic [`SCALAR_IMM_WIDTH-1:0] imm;
		// Spare low bits
		logic [3:0] reserved;
	} instr_t;

	// Decode stage register
	typedef struct packed {
		logic valid;
		logic is_vector;
		opcode_t opcode;
		reg_index_t dst;
		reg_index_t src1;
		reg_index_t src2;
		data_t imm;
		logic is_halt;
	} decoded_t;

	// Operand stage register
	typedef struct packed {
		decoded_t ctrl;
		data_t a;
		data_t b;
	} operand_t;

	// Write-back and bypass source
	typedef struct packed {
		logic valid;
		reg_index_t dst;
		data_t data;
	} result_t;

	// Command toward the vector unit
	typedef struct packed {
		opcode_t opcode;
		reg_index_t vdst;
		reg_index_t vsrc;
		data_t scalar;
	} vector_command_t;

endpackage

`default_nettype wire

// ==== source/instr_store.sv ====
//////////////////////////////
// Instruction memory with store
// handshake and registered read
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module instr_store (
	input wire logic clock,
	input wire logic reset,
	input wire logic enable,
	input wire logic store_valid,
	input wire scalar_pkg::instr_t store_instr,
	output logic store_ready,
	input wire logic read_request,
	input wire logic [`SCALAR_ADDR_WIDTH-1:0] read_address,
	output scalar_pkg::instr_t read_instr
);

	// One extra bit so a full memory is visible
	localparam int PTR_WIDTH = `SCALAR_ADDR_WIDTH + 1;

	scalar_pkg::instr_t mem [`SCALAR_IMEM_DEPTH];
	logic [PTR_WIDTH-1:0] store_ptr;
	logic full;
	logic store_fire;

	//////////////////////////////
	// Store side
	//////////////////////////////
	assign full = (store_ptr == PTR_WIDTH'(`SCALAR_IMEM_DEPTH));
	assign store_ready = ~full & ~enable;
	assign store_fire = store_valid & store_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			store_ptr <= '0;
		end else if (store_fire) begin
			store_ptr <= store_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (store_fire) begin
			mem[store_ptr[`SCALAR_ADDR_WIDTH-1:0]] <= store_instr;
		end
	end

	//////////////////////////////
	// Fetch side
	//////////////////////////////
	// Output holds while no request is made
	always_ff @(posedge clock) begin
		if (read_request) begin
			read_instr <= mem[read_address];
		end
	end

	// Fetch never runs past the loaded program
	read_in_program: assert property (@(posedge clock) disable iff (reset)
		read_request |-> ({1'b0, read_address} < store_ptr));

endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
//////////////////////////////
// Program counter and fetch request
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module fetch_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic advance,
	input wire logic stop,
	output logic read_request,
	output logic [`SCALAR_ADDR_WIDTH-1:0] read_address,
	output logic fetch_valid
);

	logic [`SCALAR_ADDR_WIDTH-1:0] pc;

	// Request only when the whole pipe moves
	assign read_request = advance & ~stop;
	assign read_address = pc;

	// Valid tag trails the request by one cycle, like the memory data
	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			fetch_valid <= 1'b0;
		end else if (advance) begin
			fetch_valid <= ~stop;
			if (~stop) begin
				pc <= pc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
//////////////////////////////
// Field extraction, immediate
// extension and halt detection
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module decode_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic advance,
	input wire logic fetch_valid,
	input wire scalar_pkg::instr_t fetch_instr,
	output logic stop,
	output scalar_pkg::decoded_t decoded
);

	localparam int EXT_WIDTH = `SCALAR_DATA_WIDTH - `SCALAR_IMM_WIDTH;

	logic halted;
	logic halt_now;
	scalar_pkg::decoded_t next;

	// Halt is a scalar opcode only
	assign halt_now = fetch_valid & ~fetch_instr.unit
		& (fetch_instr.opcode == `SCALAR_OP_HALT);

	// Fetch stops once the halt is registered
	assign stop = halted;

	always_comb begin
		next.valid = fetch_valid & ~halted;
		next.is_vector = fetch_instr.unit;
		next.opcode = fetch_instr.opcode;
		next.dst = fetch_instr.dst;
		next.src1 = fetch_instr.src1;
		next.src2 = fetch_instr.src2;
		next.imm = {{EXT_WIDTH{fetch_instr.imm[`SCALAR_IMM_WIDTH-1]}}, fetch_instr.imm};
		next.is_halt = halt_now;
	end

	//////////////////////////////
	// Stage register
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			halted <= 1'b0;
			decoded.valid <= 1'b0;
		end else if (advance) begin
			// Sticky until reset so every later word is squashed
			halted <= halted | halt_now;
			decoded <= next;
		end
	end

endmodule

`default_nettype wire

// ==== source/operand_stage.sv ====
//////////////////////////////
// Register file and the
// two-source bypass network
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module operand_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic advance,
	input wire scalar_pkg::decoded_t decoded,
	input wire scalar_pkg::result_t write_back,
	input wire scalar_pkg::result_t in_flight,
	output scalar_pkg::operand_t operands
);

	scalar_pkg::data_t regs [`SCALAR_REG_COUNT];
	scalar_pkg::data_t value_a;
	scalar_pkg::data_t value_b;

	//////////////////////////////
	// Register file
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `SCALAR_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_back.valid) begin
			regs[write_back.dst] <= write_back.data;
		end
	end

	//////////////////////////////
	// Bypass
	//////////////////////////////
	// Youngest result wins, then the one being written, then the file
	function automatic scalar_pkg::data_t pick_operand(
		input scalar_pkg::reg_index_t src,
		input scalar_pkg::result_t from_execute,
		input scalar_pkg::result_t from_write_back,
		input scalar_pkg::data_t from_file
	);
		if (from_execute.valid && (from_execute.dst == src)) begin
			return from_execute.data;
		end
		if (from_write_back.valid && (from_write_back.dst == src)) begin
			return from_write_back.data;
		end
		return from_file;
	endfunction

	assign value_a = pick_operand(decoded.src1, in_flight, write_back, regs[decoded.src1]);
	assign value_b = pick_operand(decoded.src2, in_flight, write_back, regs[decoded.src2]);

	//////////////////////////////
	// Stage register
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			operands.ctrl.valid <= 1'b0;
		end else if (advance) begin
			operands.ctrl <= decoded;
			operands.a <= value_a;
			operands.b <= value_b;
		end
	end

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
//////////////////////////////
// ALU, write-back, vector command
// register and advance control
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module execute_stage (
	input wire logic clock,
	input wire logic reset,
	input wire logic enable,
	input wire scalar_pkg::operand_t operands,
	input wire logic vcmd_ready,
	output logic advance,
	output scalar_pkg::result_t in_flight,
	output scalar_pkg::result_t write_back,
	output logic vcmd_valid,
	output scalar_pkg::vector_command_t vcmd,
	output logic term
);

	scalar_pkg::data_t alu_result;
	logic scalar_write;
	logic vector_issue;
	logic halt_leaving;

	// Whole pipe freezes behind a command nobody took
	assign advance = enable & ~(vcmd_valid & ~vcmd_ready);

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (operands.ctrl.opcode)
			`SCALAR_OP_ADD: alu_result = operands.a + operands.b;
			`SCALAR_OP_SUB: alu_result = operands.a - operands.b;
			`SCALAR_OP_AND: alu_result = operands.a & operands.b;
			`SCALAR_OP_OR: alu_result = operands.a | operands.b;
			`SCALAR_OP_XOR: alu_result = operands.a ^ operands.b;
			`SCALAR_OP_LI: alu_result = operands.ctrl.imm;
			default: alu_result = '0;
		endcase
	end

	// NOP and halt write nothing
	assign scalar_write = operands.ctrl.valid & ~operands.ctrl.is_vector
		& ~operands.ctrl.is_halt & (operands.ctrl.opcode != `SCALAR_OP_NOP);
	assign vector_issue = operands.ctrl.valid & operands.ctrl.is_vector;
	assign halt_leaving = advance & operands.ctrl.valid & operands.ctrl.is_halt;

	assign in_flight.valid = scalar_write;
	assign in_flight.dst = operands.ctrl.dst;
	assign in_flight.data = alu_result;

	//////////////////////////////
	// Write-back register
	//////////////////////////////
	// Valid for one cycle per instruction, the file keeps it afterwards
	always_ff @(posedge clock) begin
		if (reset) begin
			write_back.valid <= 1'b0;
		end else begin
			write_back.valid <= advance & in_flight.valid;
			write_back.dst <= in_flight.dst;
			write_back.data <= in_flight.data;
		end
	end

	//////////////////////////////
	// Vector command register
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			vcmd_valid <= 1'b0;
		end else if (advance) begin
			vcmd_valid <= vector_issue;
		end else if (vcmd_ready) begin
			// Taken while enable is low
			vcmd_valid <= 1'b0;
		end
	end

	// Scalar value comes from the src1 read
	always_ff @(posedge clock) begin
		if (advance && vector_issue) begin
			vcmd.opcode <= operands.ctrl.opcode;
			vcmd.vdst <= operands.ctrl.dst;
			vcmd.vsrc <= operands.ctrl.src2;
			vcmd.scalar <= operands.a;
		end
	end

	// Termination flag, held until reset
	always_ff @(posedge clock) begin
		if (reset) begin
			term <= 1'b0;
		end else if (halt_leaving) begin
			term <= 1'b1;
		end
	end

	// A command under back-pressure must not change
	vcmd_held: assert property (@(posedge clock) disable iff (reset)
		(vcmd_valid && !vcmd_ready) |=> (vcmd_valid && $stable(vcmd)));

endmodule

`default_nettype wire

// ==== source/scalar_unit.sv ====
//////////////////////////////
// Scalar unit top level
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "scalar_config.svh"

module scalar_unit (
	input wire logic clock,
	input wire logic reset,
	input wire logic enable,
	input wire logic store_valid,
	input wire scalar_pkg::instr_t store_instr,
	output logic store_ready,
	output logic vcmd_valid,
	output scalar_pkg::vector_command_t vcmd,
	input wire logic vcmd_ready,
	output logic term
);

	logic advance;
	logic stop;
	logic read_request;
	logic [`SCALAR_ADDR_WIDTH-1:0] read_address;
	logic fetch_valid;
	scalar_pkg::instr_t fetch_instr;
	scalar_pkg::decoded_t decoded;
	scalar_pkg::operand_t operands;
	scalar_pkg::result_t write_back;
	scalar_pkg::result_t in_flight;

	//////////////////////////////
	// Front end
	//////////////////////////////
	instr_store imem (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.store_valid(store_valid),
		.store_instr(store_instr),
		.store_ready(store_ready),
		.read_request(read_request),
		.read_address(read_address),
		.read_instr(fetch_instr)
	);

	fetch_stage fetch (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.stop(stop),
		.read_request(read_request),
		.read_address(read_address),
		.fetch_valid(fetch_valid)
	);

	decode_stage decode (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.fetch_valid(fetch_valid),
		.fetch_instr(fetch_instr),
		.stop(stop),
		.decoded(decoded)
	);

	//////////////////////////////
	// Back end
	//////////////////////////////
	operand_stage operand (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.decoded(decoded),
		.write_back(write_back),
		.in_flight(in_flight),
		.operands(operands)
	);

	execute_stage execute (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.operands(operands),
		.vcmd_ready(vcmd_ready),
		.advance(advance),
		.in_flight(in_flight),
		.write_back(write_back),
		.vcmd_valid(vcmd_valid),
		.vcmd(vcmd),
		.term(term)
	);

endmodule

`default_nettype wire

// ==== test/scalar_unit_tb.sv ====
//////////////////////////////
// Scalar unit testbench with program load, command
// checks, back-pressure and termination
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module scalar_unit_tb;

	localparam logic [31:0] SEED = 32'h359ac301;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic enable = 1'b0;
	logic store_valid = 1'b0;
	scalar_pkg::instr_t store_instr = '0;
	logic store_ready;
	logic vcmd_valid;
	scalar_pkg::vector_command_t vcmd;
	logic vcmd_ready = 1'b0;
	logic term;

	// Run control changes on the rising edge like the DUT inputs
	logic running = 1'b0;
	logic pressure = 1'b0;
	logic [31:0] lcg_state = SEED;
	string run_label = "";

	scalar_pkg::instr_t program_words[$];
	scalar_pkg::vector_command_t expected_commands[$];

	int error_count = 0;
	int check_count = 0;
	int store_count = 0;
	int taken_count = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;
	logic held = 1'b0;
	scalar_pkg::vector_command_t held_cmd;

	scalar_unit UUT (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.store_valid(store_valid),
		.store_instr(store_instr),
		.store_ready(store_ready),
		.vcmd_valid(vcmd_valid),
		.vcmd(vcmd),
		.vcmd_ready(vcmd_ready),
		.term(term)
	);

	always #50 clock = ~clock;

	//////////////////////////////
	// Checks
	//////////////////////////////
	task automatic check_flag(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic string command_text(input scalar_pkg::vector_command_t cmd);
		return $sformatf("op %h vdst %h vsrc %h scalar %h",
			cmd.opcode, cmd.vdst, cmd.vsrc, cmd.scalar);
	endfunction

	task automatic check_command(input string name,
		input scalar_pkg::vector_command_t expected,
		input scalar_pkg::vector_command_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Fail %s: expected %s, actual %s",
				name, command_text(expected), command_text(actual));
		end
	endtask

	//////////////////////////////
	// Stimulus sources
	//////////////////////////////
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Bit 16 drives ready because the low state bits repeat too fast
	always @(posedge clock) begin
		lcg_state <= lcg_next(lcg_state);
		vcmd_ready <= ~pressure | lcg_state[16];
		enable <= running & (~pressure | lcg_state[20] | lcg_state[21]);
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Error: the run did not end within %0d cycles", cycle_limit);
			$display("Checks: %0d, errors: %0d", check_count, error_count + 1);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Outputs are sampled on the falling edge where they are settled
	always @(negedge clock) begin
		if (reset) begin
			store_count = 0;
			taken_count = 0;
			held = 1'b0;
		end else begin
			if (store_valid && store_ready) begin
				store_count++;
			end
			if (enable) begin
				check_flag({run_label, " store_ready while enabled"}, 1'b0, store_ready);
			end
			if (held) begin
				check_flag({run_label, " vcmd_valid while held"}, 1'b1, vcmd_valid);
				check_command({run_label, " vcmd while held"}, held_cmd, vcmd);
			end
			if (vcmd_valid && vcmd_ready) begin
				if (taken_count < expected_commands.size()) begin
					check_command($sformatf("%s command %0d", run_label, taken_count),
						expected_commands[taken_count], vcmd);
				end else begin
					error_count++;
					$display("Error: %s run issued a command beyond the expected list",
						run_label);
				end
				taken_count++;
			end
			held = vcmd_valid & ~vcmd_ready;
			held_cmd = vcmd;
		end
	end

	//////////////////////////////
	// Data file and run sequence
	//////////////////////////////
	task automatic read_data_file;
		int fd;
		int ch;
		int count;
		logic [31:0] word;
		logic [31:0] op;
		logic [31:0] vdst;
		logic [31:0] vsrc;
		logic [31:0] scalar;
		scalar_pkg::vector_command_t cmd;
		fd = $fopen("test/scalar_unit_input.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open test/scalar_unit_input.txt");
			error_count++;
		end else begin
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == "#") begin
					while (ch != -1 && ch != 10) begin
						ch = $fgetc(fd);
					end
				end else if (ch == "I") begin
					count = $fscanf(fd, "%h", word);
					if (count == 1) begin
						program_words.push_back(word);
					end
				end else if (ch == "E") begin
					count = $fscanf(fd, "%h %h %h %h", op, vdst, vsrc, scalar);
					if (count == 4) begin
						cmd.opcode = op[2:0];
						cmd.vdst = vdst[3:0];
						cmd.vsrc = vsrc[3:0];
						cmd.scalar = scalar;
						expected_commands.push_back(cmd);
					end
				end
				if (ch != -1) begin
					ch = $fgetc(fd);
				end
			end
			$fclose(fd);
		end
	endtask

	// The next word goes out on the edge that takes the current one
	task automatic load_program;
		for (int i = 0; i < program_words.size(); i++) begin
			@(posedge clock);
			store_valid <= 1'b1;
			store_instr <= program_words[i];
			@(negedge clock);
			while (!store_ready) begin
				@(negedge clock);
			end
		end
		@(posedge clock);
		store_valid <= 1'b0;
	endtask

	task automatic run_program(input logic random_pressure, input string name);
		@(posedge clock);
		run_label = name;
		running <= 1'b0;
		pressure <= random_pressure;
		reset <= 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_flag({name, " store_ready after reset"}, 1'b1, store_ready);
		check_flag({name, " term after reset"}, 1'b0, term);
		check_flag({name, " vcmd_valid after reset"}, 1'b0, vcmd_valid);
		load_program();
		if (store_count != program_words.size()) begin
			error_count++;
			$display("Error: %s run stored %0d words instead of %0d",
				name, store_count, program_words.size());
		end
		running <= 1'b1;
		@(negedge clock);
		while (!term) begin
			@(negedge clock);
		end
		@(posedge clock);
		if (taken_count != expected_commands.size()) begin
			error_count++;
			$display("Error: %s run ended after %0d of %0d commands",
				name, taken_count, expected_commands.size());
		end
		// Quiet period in which nothing past the halt may show up
		repeat (20) @(posedge clock);
		@(negedge clock);
		check_flag({name, " term held"}, 1'b1, term);
		@(posedge clock);
		running <= 1'b0;
	endtask

	initial begin
		read_data_file();
		cycle_limit = 2 * (20 * program_words.size() + 200);
		if (program_words.size() == 0 || expected_commands.size() == 0) begin
			$display("Error: the data file holds no program or no expected commands");
			error_count++;
		end else begin
			run_program(1'b0, "steady");
			run_program(1'b1, "pressure");
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/scalar_pkg.sv
source/instr_store.sv
source/fetch_stage.sv
source/decode_stage.sv
source/operand_stage.sv
source/execute_stage.sv
source/scalar_unit.sv
test/scalar_unit_tb.sv

// ==== test/scalar_unit_input.txt ====
# I <instruction word, hex>: program word, stored in order from address 0
# E <opcode> <vdst> <vsrc> <scalar>: expected vector command, hex, in issue order
I 610005a0  # li  r1, 0x05a
I 62001230  # li  r2, 0x123
I 13120000  # add r3, r1, r2
I 91320000  # vec op1 v1, r3, v2
E 1 1 2 0000017d
I 24310000  # sub r4, r3, r1
I 24430000  # sub r4, r4, r3
I a4450000  # vec op2 v4, r4, v5
E 2 4 5 ffffffa6
I 6500fff0  # li  r5, 0xfff
I 36520000  # and r6, r5, r2
I 46610000  # or  r6, r6, r1
I 57650000  # xor r7, r6, r5
I b7760000  # vec op3 v7, r7, v6
E 3 7 6 fffffe84
I 68008000  # li  r8, 0x800
I 58860000  # xor r8, r8, r6
I c8810000  # vec op4 v8, r8, v1
E 4 8 1 fffff97b
I d2130000  # vec op5 v2, r1, v3
E 5 2 3 0000005a
I 00000000  # nop
I 19470000  # add r9, r4, r7
I e9940000  # vec op6 v9, r9, v4
E 6 9 4 fffffe2a
I 70000000  # halt
# Words past the halt, never issued
I ff1f0000  # vec op7 v15, r1, v15
I 61007ff0  # li  r1, 0x7ff
